/* test/istream_patterns.txt */
# S <pc> <mask> <parcel 0> .. <parcel 7> is a fetch set, R is a restart
# E <instr> <uncompressed> <pc> is the next expected instruction
S 00001000 ff 1100 1101 1102 1104 1105 1106 1108 1109
E 00001100 0 00001000
E 00001101 0 00001002
E 00001102 0 00001004
E 00001104 0 00001006
E 00001105 0 00001008
E 00001106 0 0000100a
E 00001108 0 0000100c
E 00001109 0 0000100e
S 00001010 ff abc3 5678 0001 00b7 dead 4002 8000 3f2f
E 5678abc3 1 00001010
E 00000001 0 00001014
E dead00b7 1 00001016
E 00004002 0 0000101a
E 00008000 0 0000101c
S 00001020 32 ffff 1113 ffff ffff 0004 0009 ffff ffff
E 11133f2f 1 0000101e
E 00000004 0 00001028
E 00000009 0 0000102a
S 00001030 00 ffff ffff ffff ffff ffff ffff ffff ffff
S 00002000 01 0100 ffff ffff ffff ffff ffff ffff ffff
E 00000100 0 00002000
S 00002010 04 ffff ffff 0204 ffff ffff ffff ffff ffff
E 00000204 0 00002014
S 00002020 80 ffff ffff ffff ffff ffff ffff ffff 0308
E 00000308 0 0000202e
S 00002030 30 ffff ffff ffff ffff 0403 0404 ffff ffff
E 04040403 1 00002038
S 00002040 02 ffff 0502 ffff ffff ffff ffff ffff ffff
E 00000502 0 00002042
S 00002050 40 ffff ffff ffff ffff ffff ffff 060c ffff
E 0000060c 0 0000205c
S 00003000 80 ffff ffff ffff ffff ffff ffff ffff bee3
R
S 00003010 07 7770 0007 9999 ffff ffff ffff ffff ffff
E 00007770 0 00003010
E 99990007 1 00003012

/* all.f */
rtl/istream_pkg.sv
rtl/set_predecoder.sv
rtl/set_queue.sv
rtl/instr_aligner.sv
rtl/way_packer.sv
rtl/istream_top.sv
test/tb_istream.sv

/* Makefile */
# Verilator build and run of the instruction stream buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_istream
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(shell cat $(FILELIST))
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_istream.sv */
// --------------------------------------------------------------------
// testbench for the instruction stream buffer
// sets, restarts and expected instructions come from
// test/istream_patterns.txt, so the run starts in the project root
// out_ready is held low at first so that the queue fills up
// --------------------------------------------------------------------
`timescale 1ns/1ns

module tb_istream;

    localparam int    SET_COUNT    = 8;
    localparam string PATTERN_FILE = "test/istream_patterns.txt";

    logic                                      CLK;
    logic                                      nRST;
    logic                                      restart;
    istream_pkg::fetch_set_t                   in_set;
    logic                                      in_valid;
    logic                                      in_ready;
    istream_pkg::way_t [istream_pkg::WAYS-1:0] out_ways;
    logic                                      out_valid;
    logic                                      out_ready = 1'b0;

    // commands in file order and expected ways in program order
    byte                     cmd_kind [$];
    istream_pkg::fetch_set_t cmd_set [$];
    int                      cmd_exp_before [$];
    istream_pkg::way_t       exp_q [$];

    int   line_count = 0;
    int   matched    = 0;
    int   cycles     = 0;
    int   limit      = 0;
    int   ready_hold = 28;
    logic running    = 1'b0;
    logic saw_full   = 1'b0;

    istream_top #(
        .SET_COUNT (SET_COUNT)
    ) u_istream_top (
        .CLK       (CLK),
        .nRST      (nRST),
        .restart   (restart),
        .in_set    (in_set),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_ways  (out_ways),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // --------------------------------------------------------------------
    // pattern reader

    task automatic load_patterns();
        int                      fd;
        int                      n;
        string                   line;
        byte                     tag;
        logic [31:0]             pc;
        logic [31:0]             instr;
        logic [7:0]              mask;
        logic                    unc;
        logic [15:0]             p0, p1, p2, p3, p4, p5, p6, p7;
        istream_pkg::fetch_set_t s;
        istream_pkg::way_t       e;
        fd = $fopen(PATTERN_FILE, "r");
        assert (fd != 0) else begin
            $display("TEST FAIL");
            $fatal(1, "cannot open pattern file %s", PATTERN_FILE);
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n <= 0 || line.len() == 0) continue;
            tag = line.getc(0);
            s   = '0;
            case (tag)
                "S": begin
                    n = $sscanf(line, "S %h %h %h %h %h %h %h %h %h %h",
                                pc, mask, p0, p1, p2, p3, p4, p5, p6, p7);
                    s.pc      = pc;
                    s.valid   = mask;
                    s.parcels = {p7, p6, p5, p4, p3, p2, p1, p0};
                end
                "E": begin
                    n = $sscanf(line, "E %h %h %h", instr, unc, pc);
                    e.valid        = 1'b1;
                    e.uncompressed = unc;
                    e.instr        = instr;
                    e.pc           = pc;
                    exp_q.push_back(e);
                end
                default: ;
            endcase
            if (tag == "S" || tag == "R") begin
                cmd_kind.push_back(tag);
                cmd_set.push_back(s);
                cmd_exp_before.push_back(exp_q.size());
            end
            if (tag == "S" || tag == "R" || tag == "E") line_count++;
        end
        $fclose(fd);
    endtask

    // --------------------------------------------------------------------
    // stimulus driven on the falling edge

    task automatic send_set(input istream_pkg::fetch_set_t s);
        logic taken;
        taken = 1'b0;
        while ($urandom_range(3) == 0) @(negedge CLK);
        in_set   = s;
        in_valid = 1'b1;
        while (!taken) begin
            // in_ready only moves at rising edges
            taken = in_ready;
            if (!in_ready) saw_full = 1'b1;
            @(negedge CLK);
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_matched(input int n);
        while (matched < n) @(negedge CLK);
    endtask

    task automatic check_way(input int w, input istream_pkg::way_t got);
        istream_pkg::way_t want;
        assert (matched < exp_q.size()) else begin
            $display("TEST FAIL");
            $fatal(1, "way %0d gave %h at pc %h past the end of the expected list",
                   w, got.instr, got.pc);
        end
        want = exp_q[matched];
        assert (got.instr == want.instr && got.uncompressed == want.uncompressed
                && got.pc == want.pc) else begin
            $display("Fail at %0t: way %0d got %h unc %0d pc %h, expected %h unc %0d pc %h",
                     $time, w, got.instr, got.uncompressed, got.pc,
                     want.instr, want.uncompressed, want.pc);
            $display("TEST FAIL");
            $fatal(1, "wrong instruction on way %0d", w);
        end
        matched++;
    endtask

    // ways visible now are taken at the next rising edge
    always @(negedge CLK) begin
        logic gap;
        gap = 1'b0;
        if (running) begin
            if (ready_hold > 0) begin
                out_ready  = 1'b0;
                ready_hold = ready_hold - 1;
            end else begin
                out_ready = ($urandom_range(9) < 7);
            end
            assert (out_valid == out_ways[0].valid) else begin
                $display("Fail at %0t: out_valid %0d while way 0 valid is %0d",
                         $time, out_valid, out_ways[0].valid);
                $display("TEST FAIL");
                $fatal(1, "out_valid does not follow way 0");
            end
            if (out_valid && out_ready) begin
                for (int w = 0; w < istream_pkg::WAYS; w++) begin
                    if (out_ways[w].valid) begin
                        assert (!gap) else begin
                            $display("TEST FAIL");
                            $fatal(1, "way %0d is valid after an empty way", w);
                        end
                        check_way(w, out_ways[w]);
                    end else begin
                        gap = 1'b1;
                    end
                end
            end
        end
    end

    always @(posedge CLK) begin
        cycles++;
        assert (limit == 0 || cycles <= limit) else begin
            $display("TEST FAIL");
            $fatal(1, "timeout, run did not finish within %0d cycles", limit);
        end
    end

    initial begin
        void'($urandom(32'hade3_2e57));
        nRST     = 1'b0;
        restart  = 1'b0;
        in_valid = 1'b0;
        in_set   = '0;
        load_patterns();
        limit = 40 * line_count + 200;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);
        assert (!out_valid && in_ready) else begin
            $display("TEST FAIL");
            $fatal(1, "buffer not empty and ready after reset");
        end
        running = 1'b1;
        foreach (cmd_kind[k]) begin
            if (cmd_kind[k] == "R") begin
                wait_matched(cmd_exp_before[k]);
                @(negedge CLK);
                restart = 1'b1;
                @(negedge CLK);
                restart = 1'b0;
            end else begin
                send_set(cmd_set[k]);
            end
        end
        wait_matched(exp_q.size());
        repeat (8) @(negedge CLK);
        if (saw_full && !out_valid) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1, "in_ready never fell or instructions were left over at the end");
        end
    end

endmodule

/* rtl/istream_top.sv */
// --------------------------------------------------------------------
// instruction stream buffer top level
// valid/ready on both sides, out_ways is combinational from queue state
// SET_COUNT is the queue depth in fetch sets, a power of two
// restart empties the buffer at the next edge
// --------------------------------------------------------------------
`timescale 1ns/1ns

module istream_top #(
    parameter int SET_COUNT = 8
) (
    input  logic                                      CLK,
    input  logic                                      nRST,
    input  logic                                      restart,
    input  istream_pkg::fetch_set_t                   in_set,
    input  logic                                      in_valid,
    output logic                                      in_ready,
    output istream_pkg::way_t [istream_pkg::WAYS-1:0] out_ways,
    output logic                                      out_valid,
    input  logic                                      out_ready
);

    istream_pkg::fetch_set_t                   enq_set;
    istream_pkg::set_marks_t                   enq_marks;
    logic                                      enq_valid;
    logic                                      enq_ready;
    istream_pkg::window_t                      window;
    logic [istream_pkg::WINDOW-1:0]            consume;
    istream_pkg::way_sel_t [istream_pkg::WAYS-1:0] sel;

    set_predecoder u_set_predecoder (
        .CLK       (CLK),
        .nRST      (nRST),
        .restart   (restart),
        .in_set    (in_set),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .enq_set   (enq_set),
        .enq_marks (enq_marks),
        .enq_valid (enq_valid),
        .enq_ready (enq_ready)
    );

    set_queue #(
        .SET_COUNT (SET_COUNT)
    ) u_set_queue (
        .CLK       (CLK),
        .nRST      (nRST),
        .restart   (restart),
        .enq_set   (enq_set),
        .enq_marks (enq_marks),
        .enq_valid (enq_valid),
        .enq_ready (enq_ready),
        .window    (window),
        .consume   (consume),
        .deq_ready (out_ready)
    );

    instr_aligner u_instr_aligner (
        .window  (window),
        .consume (consume),
        .sel     (sel)
    );

    way_packer u_way_packer (
        .window (window),
        .sel    (sel),
        .ways   (out_ways)
    );

    assign out_valid = sel[0].valid;

endmodule

/* rtl/way_packer.sv */
// --------------------------------------------------------------------
// output side of the stream buffer
// builds each way's instruction word from the one-hot parcel picks
// compressed instructions come out with the upper half zero
// the pc is the set pc of the lower parcel with bits 3..1 replaced
// --------------------------------------------------------------------
`timescale 1ns/1ns

module way_packer (
    input  istream_pkg::window_t                          window,
    input  istream_pkg::way_sel_t [istream_pkg::WAYS-1:0] sel,
    output istream_pkg::way_t [istream_pkg::WAYS-1:0]     ways
);

    localparam int N    = istream_pkg::SET_PARCELS;
    localparam int W    = istream_pkg::WINDOW;
    localparam int WAYS = istream_pkg::WAYS;
    localparam int PC_W = istream_pkg::PC_W;

    istream_pkg::parcel_t [WAYS-1:0] lower_parcel;
    istream_pkg::parcel_t [WAYS-1:0] upper_parcel;
    logic [WAYS-1:0][2:0]            lower_pos;
    logic [WAYS-1:0]                 in_second;
    logic [WAYS-1:0][PC_W-1:0]       set_pc;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            lower_parcel[w] = '0;
            upper_parcel[w] = '0;
            lower_pos[w]    = '0;
            for (int i = 0; i < W; i++) begin
                if (sel[w].lower[i]) begin
                    lower_parcel[w] = lower_parcel[w] | window.parcels[i];
                    lower_pos[w]    = lower_pos[w] | 3'(i % N);
                end
                if (sel[w].upper[i]) begin
                    upper_parcel[w] = upper_parcel[w] | window.parcels[i];
                end
            end
            // lower parcel in the second head set
            in_second[w] = |sel[w].lower[W-1:N];
            set_pc[w]    = window.pc[in_second[w]];

            ways[w].valid        = sel[w].valid;
            ways[w].uncompressed = |(sel[w].lower & window.uncompressed);
            ways[w].instr        = {upper_parcel[w], lower_parcel[w]};
            ways[w].pc           = {set_pc[w][PC_W-1:4], lower_pos[w], set_pc[w][0]};
        end
    end

    // picks are one-hot or empty or parcels would be merged
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            a_sel_onehot: assert ($onehot0(sel[w].lower) && $onehot0(sel[w].upper))
                else $error("way %0d select is not one-hot", w);
        end
    end

endmodule

/* rtl/instr_aligner.sv */
// --------------------------------------------------------------------
// picks up to four instructions from the two head sets
// a chain of lowest-first searches over the start mask gives each way
// its lower parcel, an uncompressed start also takes the next valid
// parcel above it
// a way is offered only when complete and all earlier ways are too
// --------------------------------------------------------------------
`timescale 1ns/1ns

module instr_aligner (
    input  istream_pkg::window_t                          window,
    output logic [istream_pkg::WINDOW-1:0]                consume,
    output istream_pkg::way_sel_t [istream_pkg::WAYS-1:0] sel
);

    localparam int W    = istream_pkg::WINDOW;
    localparam int WAYS = istream_pkg::WAYS;

    logic [WAYS-1:0][W-1:0] lower_req;
    logic [WAYS-1:0][W-1:0] lower_oh;
    logic [WAYS-1:0][W-1:0] upper_req;
    logic [WAYS-1:0][W-1:0] upper_oh;
    logic [WAYS-1:0]        unc;
    logic [WAYS-1:0]        complete;
    logic [WAYS-1:0]        way_valid;

    function automatic logic [W-1:0] lowest_one(input logic [W-1:0] v);
        return v & (~v + W'(1));
    endfunction

    // all bits strictly above a one-hot bit, none for zero
    function automatic logic [W-1:0] above(input logic [W-1:0] oh);
        return ~(oh | (oh - W'(1)));
    endfunction

    // --------------------------------------------------------------------
    // search chain

    always_comb begin
        lower_req[0] = window.start;
        for (int w = 0; w < WAYS; w++) begin
            lower_oh[w] = lowest_one(lower_req[w]);
            if (w < WAYS - 1) begin
                lower_req[w+1] = lower_req[w] & ~lower_oh[w];
            end
            unc[w]       = |(lower_oh[w] & window.uncompressed);
            upper_req[w] = window.valid & above(lower_oh[w]);
            upper_oh[w]  = unc[w] ? lowest_one(upper_req[w]) : '0;
            complete[w]  = (|lower_oh[w]) && (!unc[w] || (|upper_req[w]));
        end
    end

    // --------------------------------------------------------------------
    // way selects and consumed parcels

    always_comb begin
        logic ok;
        ok      = 1'b1;
        consume = '0;
        for (int w = 0; w < WAYS; w++) begin
            ok           = ok && complete[w];
            way_valid[w] = ok;
            sel[w].valid = ok;
            sel[w].lower = ok ? lower_oh[w] : '0;
            sel[w].upper = ok ? upper_oh[w] : '0;
            consume      = consume | sel[w].lower | sel[w].upper;
        end
    end

    // a hole in the ways would reorder the stream
    always_comb begin
        a_ways_contiguous: assert ((way_valid & (way_valid + WAYS'(1))) == '0)
            else $error("aligner offered ways with a gap");
    end

endmodule

/* rtl/set_queue.sv */
// --------------------------------------------------------------------
// circular store of fetch sets and their parcel marks
// SET_COUNT must be a power of two and at least 2
// consumed parcels lose their valid and start bits
// a head set pops once none of its valid parcels remain
// sets with an empty mask are accepted but not stored
// --------------------------------------------------------------------
`timescale 1ns/1ns

module set_queue #(
    parameter int SET_COUNT = 8
) (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  logic                                 restart,
    input  istream_pkg::fetch_set_t              enq_set,
    input  istream_pkg::set_marks_t              enq_marks,
    input  logic                                 enq_valid,
    output logic                                 enq_ready,
    output istream_pkg::window_t                 window,
    input  logic [istream_pkg::WINDOW-1:0]       consume,
    input  logic                                 deq_ready
);

    localparam int PTR_W = $clog2(SET_COUNT);
    localparam int N     = istream_pkg::SET_PARCELS;

    istream_pkg::fetch_set_t set_mem   [SET_COUNT];
    istream_pkg::set_marks_t marks_mem [SET_COUNT];

    // pointers carry one wrap bit above the index
    logic [PTR_W:0]   enq_ptr;
    logic [PTR_W:0]   head_ptr;
    logic [PTR_W:0]   count;
    logic [PTR_W-1:0] h0_idx;
    logic [PTR_W-1:0] h1_idx;
    logic             full;
    logic             present0;
    logic             present1;
    logic             do_write;
    logic             done0;
    logic             done1;
    logic [1:0]       pop_cnt;

    assign count     = enq_ptr - head_ptr;
    assign full      = count == (PTR_W+1)'(SET_COUNT);
    assign present0  = count != '0;
    assign present1  = count > (PTR_W+1)'(1);
    assign h0_idx    = head_ptr[PTR_W-1:0];
    assign h1_idx    = h0_idx + PTR_W'(1);
    assign enq_ready = !full;
    assign do_write  = enq_valid && !full && !restart && (enq_marks.valid != '0);

    // --------------------------------------------------------------------
    // window of the two oldest sets

    always_comb begin
        window                  = '0;
        window.present          = {present1, present0};
        window.pc[0]            = set_mem[h0_idx].pc;
        window.pc[1]            = set_mem[h1_idx].pc;
        window.parcels[N-1:0]   = set_mem[h0_idx].parcels;
        window.parcels[2*N-1:N] = set_mem[h1_idx].parcels;
        if (present0) begin
            window.valid[N-1:0]        = marks_mem[h0_idx].valid;
            window.uncompressed[N-1:0] = marks_mem[h0_idx].uncompressed;
            window.start[N-1:0]        = marks_mem[h0_idx].start;
        end
        if (present1) begin
            window.valid[2*N-1:N]        = marks_mem[h1_idx].valid;
            window.uncompressed[2*N-1:N] = marks_mem[h1_idx].uncompressed;
            window.start[2*N-1:N]        = marks_mem[h1_idx].start;
        end
    end

    // --------------------------------------------------------------------
    // pops

    assign done0 = present0 && ((window.valid[N-1:0] & ~consume[N-1:0]) == '0);
    assign done1 = done0 && present1
                   && ((window.valid[2*N-1:N] & ~consume[2*N-1:N]) == '0);
    assign pop_cnt = deq_ready ? ({1'b0, done0} + {1'b0, done1}) : 2'd0;

    always_ff @(posedge CLK) begin
        if (!nRST || restart) begin
            enq_ptr  <= '0;
            head_ptr <= '0;
        end else begin
            if (do_write) begin
                enq_ptr <= enq_ptr + (PTR_W+1)'(1);
            end
            head_ptr <= head_ptr + (PTR_W+1)'(pop_cnt);
        end
    end

    // --------------------------------------------------------------------
    // storage

    always_ff @(posedge CLK) begin
        if (deq_ready && !restart) begin
            if (present0) begin
                marks_mem[h0_idx].valid <= marks_mem[h0_idx].valid & ~consume[N-1:0];
                marks_mem[h0_idx].start <= marks_mem[h0_idx].start & ~consume[N-1:0];
            end
            if (present1) begin
                marks_mem[h1_idx].valid <= marks_mem[h1_idx].valid & ~consume[2*N-1:N];
                marks_mem[h1_idx].start <= marks_mem[h1_idx].start & ~consume[2*N-1:N];
            end
        end
        // never lands on a present entry since the queue is not full
        if (do_write) begin
            set_mem[enq_ptr[PTR_W-1:0]]   <= enq_set;
            marks_mem[enq_ptr[PTR_W-1:0]] <= enq_marks;
        end
    end

    // full queue holds its tail until a set leaves or a restart
    a_no_enq_full: assert property (@(posedge CLK) disable iff (!nRST)
        (full && !restart) |=> (enq_ptr == $past(enq_ptr)))
        else $error("set queue took a set while full");

endmodule

/* rtl/set_predecoder.sv */
// --------------------------------------------------------------------
// input side of the stream buffer
// marks uncompressed parcels and instruction starts of each fetch set
// the start chain carries across sets through one register
// restart clears the carry and drops any set offered in that cycle
// --------------------------------------------------------------------
`timescale 1ns/1ns

module set_predecoder (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    restart,
    input  istream_pkg::fetch_set_t in_set,
    input  logic                    in_valid,
    output logic                    in_ready,
    output istream_pkg::fetch_set_t enq_set,
    output istream_pkg::set_marks_t enq_marks,
    output logic                    enq_valid,
    input  logic                    enq_ready
);

    localparam int N = istream_pkg::SET_PARCELS;

    logic         carry_unc;
    logic [N:0]   last_unc;
    logic [N-1:0] unc;
    logic         accept;

    assign enq_set   = in_set;
    assign enq_valid = in_valid;
    assign in_ready  = enq_ready;
    assign accept    = in_valid && enq_ready;

    // walk valid parcels in order
    always_comb begin
        last_unc[0] = carry_unc;
        for (int i = 0; i < N; i++) begin
            unc[i] = in_set.valid[i] && (in_set.parcels[i][1:0] == 2'b11);
            if (!in_set.valid[i]) begin
                enq_marks.start[i] = 1'b0;
                last_unc[i+1]      = last_unc[i];
            end else if (last_unc[i]) begin
                // upper half of the previous start
                enq_marks.start[i] = 1'b0;
                last_unc[i+1]      = 1'b0;
            end else begin
                enq_marks.start[i] = 1'b1;
                last_unc[i+1]      = unc[i];
            end
        end
        enq_marks.valid        = in_set.valid;
        enq_marks.uncompressed = unc;
    end

    always_ff @(posedge CLK) begin
        if (!nRST || restart) begin
            carry_unc <= 1'b0;
        end else if (accept) begin
            carry_unc <= last_unc[N];
        end
    end

endmodule

/* rtl/istream_pkg.sv */
// --------------------------------------------------------------------
// widths and types shared by the instruction stream buffer
// a fetch set is 16 bytes as eight 16-bit parcels, lowest address first
// parcel i of a set lives at the set pc with bits 3..1 equal to i
// the aligner looks at a window of the two oldest sets
// --------------------------------------------------------------------

package istream_pkg;

    localparam int PARCEL_W    = 16;
    localparam int SET_PARCELS = 8;
    localparam int WAYS        = 4;
    localparam int WINDOW      = 2 * SET_PARCELS;
    localparam int PC_W        = 32;

    typedef logic [PARCEL_W-1:0] parcel_t;

    // one fetch set as it arrives from the front end
    typedef struct packed {
        parcel_t [SET_PARCELS-1:0] parcels;
        logic [SET_PARCELS-1:0]    valid;
        logic [PC_W-1:0]           pc;
    } fetch_set_t;

    // per parcel marks made on entry
    typedef struct packed {
        logic [SET_PARCELS-1:0] valid;
        logic [SET_PARCELS-1:0] uncompressed;
        logic [SET_PARCELS-1:0] start;
    } set_marks_t;

    typedef struct packed {
        logic                  valid;
        logic                  uncompressed;
        logic [2*PARCEL_W-1:0] instr;
        logic [PC_W-1:0]       pc;
    } way_t;

    // two head sets side by side, set 0 in the low half
    typedef struct packed {
        parcel_t [WINDOW-1:0] parcels;
        logic [WINDOW-1:0]    valid;
        logic [WINDOW-1:0]    uncompressed;
        logic [WINDOW-1:0]    start;
        logic [1:0][PC_W-1:0] pc;
        logic [1:0]           present;
    } window_t;

    // one-hot parcel picks for one way
    typedef struct packed {
        logic              valid;
        logic [WINDOW-1:0] lower;
        logic [WINDOW-1:0] upper;
    } way_sel_t;

endpackage
